// ==== host_channel_pkg.sv ====
// Host channel test node shared definitions
// Message width, tester modes, CSR addresses and the control settings
// passed from the register block to the tester
package host_channel_pkg;

    // Message word and counter widths
    localparam int DATA_WIDTH  = 64;
    localparam int COUNT_WIDTH = 30;
    localparam int FIFO_DEPTH  = 4;
    localparam int DONE_WIDTH  = 8;

    // One message word on either channel direction
    typedef logic [DATA_WIDTH-1:0] t_msg;

    // Tester mode, also used as the test request code
    // NORMAL as a request means nothing is requested
    typedef enum logic [1:0]
    {
        NORMAL   = 2'd0,
        SINK     = 2'd1,
        SOURCE   = 2'd2,
        LOOPBACK = 2'd3
    } t_test_mode;

    // CSR write addresses
    typedef enum logic
    {
        CSR_CTRL = 1'b0,
        CSR_TEST = 1'b1
    } t_csr_addr;

    // Settings driven by csr_regs, read by channel_tester
    typedef struct packed
    {
        logic                   user_channel_en;
        t_test_mode             test_req;
        logic [COUNT_WIDTH-1:0] test_count;
    } t_csr_settings;

endpackage

// ==== csr_regs.sv ====
// Control register block for the host channel test node
// Four-phase req/ack write port, user channel enable, one-cycle test
// request and a count of completed tests
`timescale 1ns/100ps

module csr_regs
(
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    csr_req,
    input  host_channel_pkg::t_csr_addr             csr_addr,
    input  logic [31:0]                             csr_wdata,
    input  logic                                    test_done,
    output logic                                    csr_ack,
    output host_channel_pkg::t_csr_settings         settings,
    output logic [host_channel_pkg::DONE_WIDTH-1:0] tests_done
);

    // Handshake state, ack follows the state directly
    typedef enum logic
    {
        HS_IDLE,
        HS_ACK
    } t_hs_state;

    t_hs_state hs_state;

    logic                                     user_channel_en;
    host_channel_pkg::t_test_mode             test_req;
    logic [host_channel_pkg::COUNT_WIDTH-1:0] test_count;

    // Write strobe, taken once per handshake when req is first seen
    logic wr_en;

    assign wr_en   = (hs_state == HS_IDLE) && csr_req;
    assign csr_ack = (hs_state == HS_ACK);

    // Handshake and control registers
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            hs_state        <= HS_IDLE;
            user_channel_en <= 1'b0;
            test_req        <= host_channel_pkg::NORMAL;
        end
        else
        begin
            // Request lasts a single cycle
            test_req <= host_channel_pkg::NORMAL;

            case (hs_state)
                HS_IDLE:
                begin
                    if (csr_req)
                    begin
                        hs_state <= HS_ACK;
                        if (csr_addr == host_channel_pkg::CSR_CTRL)
                        begin
                            user_channel_en <= csr_wdata[0];
                        end
                        else
                        begin
                            test_req <= host_channel_pkg::t_test_mode'(csr_wdata[1:0]);
                        end
                    end
                end
                HS_ACK:
                begin
                    // Drop ack once the host releases req
                    if (!csr_req)
                    begin
                        hs_state <= HS_IDLE;
                    end
                end
                default:
                begin
                    hs_state <= HS_IDLE;
                end
            endcase
        end
    end

    // Source count payload, captured with the test request
    always_ff @(posedge clk)
    begin
        if (wr_en && (csr_addr == host_channel_pkg::CSR_TEST))
        begin
            test_count <= csr_wdata[2 +: host_channel_pkg::COUNT_WIDTH];
        end
    end

    // Completed tests, wraps at the counter width
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tests_done <= '0;
        end
        else if (test_done)
        begin
            tests_done <= tests_done + 1'b1;
        end
    end

    assign settings.user_channel_en = user_channel_en;
    assign settings.test_req        = test_req;
    assign settings.test_count      = test_count;

endmodule

// ==== channel_fifo.sv ====
// First-word-fall-through message FIFO
// rdy/enable on both sides; the head word is always shown at out_data
`timescale 1ns/100ps

module channel_fifo
#(
    parameter int depth = host_channel_pkg::FIFO_DEPTH
)
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  host_channel_pkg::t_msg in_data,
    input  logic                  in_enable,
    output logic                  in_rdy,
    output host_channel_pkg::t_msg out_data,
    output logic                  out_rdy,
    input  logic                  out_enable
);

    localparam int ptr_width = $clog2(depth);
    localparam int cnt_width = $clog2(depth + 1);

    host_channel_pkg::t_msg mem [depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic [cnt_width-1:0] count_next;

    // Occupancy after this cycle's push and pop
    always_comb
    begin
        count_next = count;
        if (in_enable && !out_enable)
        begin
            count_next = count + 1'b1;
        end
        else if (!in_enable && out_enable)
        begin
            count_next = count - 1'b1;
        end
    end

    // Word storage written on each push
    always_ff @(posedge clk)
    begin
        if (in_enable)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            in_rdy  <= 1'b0;
            out_rdy <= 1'b0;
        end
        else
        begin
            if (in_enable)
            begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (out_enable)
            begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count_next;
            // Flags are registered and stay low through reset
            in_rdy  <= (count_next != cnt_width'(depth));
            out_rdy <= (count_next != '0);
        end
    end

    assign out_data = mem[rd_ptr];

endmodule

// ==== channel_tester.sv ====
// Test node between the host channel FIFOs and the client port
// Passes traffic in normal mode; otherwise sinks, sources or loops back
// host messages and reports completion with a one-cycle pulse
`timescale 1ns/100ps

module channel_tester
(
    input  logic                            clk,
    input  logic                            reset_n,
    input  host_channel_pkg::t_csr_settings settings,

    // Client receive side
    output host_channel_pkg::t_msg          client_rx_data,
    output logic                            client_rx_rdy,
    input  logic                            client_rx_enable,

    // Client transmit side
    input  host_channel_pkg::t_msg          client_tx_data,
    input  logic                            client_tx_enable,
    output logic                            client_tx_rdy,

    // Receive FIFO read side
    input  host_channel_pkg::t_msg          rx_data,
    input  logic                            rx_rdy,
    output logic                            rx_enable,

    // Transmit FIFO write side
    output host_channel_pkg::t_msg          tx_data,
    input  logic                            tx_rdy,
    output logic                            tx_enable,

    output host_channel_pkg::t_test_mode    test_mode,
    output logic                            test_done
);

    localparam int pad_width = host_channel_pkg::DATA_WIDTH - host_channel_pkg::COUNT_WIDTH - 1;

    host_channel_pkg::t_test_mode mode;

    // Words left to send in SOURCE mode
    logic [host_channel_pkg::COUNT_WIDTH-1:0] source_count;
    logic                                     source_last;

    assign source_last = (source_count == host_channel_pkg::COUNT_WIDTH'(1));
    assign test_mode   = mode;

    // Routing depends on mode
    always_comb
    begin
        // Normal wiring as the default
        client_rx_data = rx_data;
        tx_data        = client_tx_data;
        client_rx_rdy  = 1'b0;
        client_tx_rdy  = 1'b0;
        rx_enable      = 1'b0;
        tx_enable      = 1'b0;
        test_done      = 1'b0;

        case (mode)
            host_channel_pkg::SINK:
            begin
                // Consume host words, only while a reply could be pushed
                rx_enable = rx_rdy && tx_rdy;
                test_done = rx_enable && rx_data[0];
                // Terminating word goes back once
                tx_data   = rx_data;
                tx_enable = test_done;
            end
            host_channel_pkg::SOURCE:
            begin
                // Drain anything the host sends meanwhile
                rx_enable = rx_rdy;
                // Count in bits 30:1, last flag in bit 0
                tx_data   = {{pad_width{1'b0}}, source_count, source_last};
                tx_enable = tx_rdy;
                test_done = tx_rdy && source_last;
            end
            host_channel_pkg::LOOPBACK:
            begin
                // Pop only when the word can go straight back
                rx_enable = rx_rdy && tx_rdy;
                tx_data   = rx_data;
                tx_enable = rx_enable;
                test_done = rx_enable && rx_data[0];
            end
            default:
            begin
                // Client connected to the FIFOs
                client_rx_rdy = rx_rdy;
                rx_enable     = client_rx_enable;
                client_tx_rdy = tx_rdy && settings.user_channel_en;
                tx_enable     = client_tx_enable;
            end
        endcase
    end

    // Down-counter, reloaded whenever not sourcing
    always_ff @(posedge clk)
    begin
        if (mode != host_channel_pkg::SOURCE)
        begin
            source_count <= settings.test_count;
        end
        else if (tx_rdy)
        begin
            source_count <= source_count - 1'b1;
        end
    end

    // Mode register
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mode <= host_channel_pkg::NORMAL;
        end
        else if (settings.test_req != host_channel_pkg::NORMAL)
        begin
            // New request overrides whatever is running
            mode <= settings.test_req;
        end
        else if (test_done)
        begin
            mode <= host_channel_pkg::NORMAL;
        end
    end

endmodule

// ==== host_channel_top.sv ====
// Host channel test node top level
// Register block, receive and transmit FIFOs and the tester
`timescale 1ns/100ps

module host_channel_top
(
    input  logic                                    clk,
    input  logic                                    reset_n,

    // CSR write port
    input  logic                                    csr_req,
    input  host_channel_pkg::t_csr_addr             csr_addr,
    input  logic [31:0]                             csr_wdata,
    output logic                                    csr_ack,

    // Host to client, host side
    input  host_channel_pkg::t_msg                  host_rx_data,
    input  logic                                    host_rx_valid,
    output logic                                    host_rx_ready,

    // Host to client, client side
    output host_channel_pkg::t_msg                  client_rx_data,
    output logic                                    client_rx_rdy,
    input  logic                                    client_rx_enable,

    // Client to host, client side
    input  host_channel_pkg::t_msg                  client_tx_data,
    input  logic                                    client_tx_enable,
    output logic                                    client_tx_rdy,

    // Client to host, host side
    output host_channel_pkg::t_msg                  host_tx_data,
    output logic                                    host_tx_valid,
    input  logic                                    host_tx_ready,

    // Status
    output host_channel_pkg::t_test_mode            test_mode,
    output logic [host_channel_pkg::DONE_WIDTH-1:0] tests_done
);

    host_channel_pkg::t_csr_settings settings;
    logic                            test_done;

    // Receive FIFO read side
    host_channel_pkg::t_msg rx_data;
    logic                   rx_rdy;
    logic                   rx_enable;

    // Transmit FIFO write side
    host_channel_pkg::t_msg tx_data;
    logic                   tx_rdy;
    logic                   tx_enable;

    csr_regs csr_regs_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .csr_req    (csr_req),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .test_done  (test_done),
        .csr_ack    (csr_ack),
        .settings   (settings),
        .tests_done (tests_done)
    );

    // Host valid/ready becomes a push on the transfer edge
    channel_fifo rx_fifo_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_data    (host_rx_data),
        .in_enable  (host_rx_valid && host_rx_ready),
        .in_rdy     (host_rx_ready),
        .out_data   (rx_data),
        .out_rdy    (rx_rdy),
        .out_enable (rx_enable)
    );

    channel_fifo tx_fifo_i
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_data    (tx_data),
        .in_enable  (tx_enable),
        .in_rdy     (tx_rdy),
        .out_data   (host_tx_data),
        .out_rdy    (host_tx_valid),
        .out_enable (host_tx_valid && host_tx_ready)
    );

    channel_tester tester_i
    (
        .clk              (clk),
        .reset_n          (reset_n),
        .settings         (settings),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_enable (client_tx_enable),
        .client_tx_rdy    (client_tx_rdy),
        .rx_data          (rx_data),
        .rx_rdy           (rx_rdy),
        .rx_enable        (rx_enable),
        .tx_data          (tx_data),
        .tx_rdy           (tx_rdy),
        .tx_enable        (tx_enable),
        .test_mode        (test_mode),
        .test_done        (test_done)
    );

endmodule

// ==== host_channel_assertions.sv ====
// Protocol checks for the host channel test node
// CSR handshake, FIFO flow and client gating during tests
`timescale 1ns/100ps

module host_channel_assertions
(
    input logic                         clk,
    input logic                         reset_n,
    input logic                         csr_req,
    input logic                         csr_ack,
    input logic                         tx_enable,
    input logic                         tx_rdy,
    input logic                         rx_enable,
    input logic                         rx_rdy,
    input logic                         client_rx_rdy,
    input logic                         client_tx_rdy,
    input host_channel_pkg::t_test_mode test_mode
);

    // Ack rises only while req is held
    ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(csr_ack) |-> csr_req)
        else $error("csr_ack rose while csr_req was low");

    // No push into a full transmit FIFO
    no_push_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        tx_enable |-> tx_rdy)
        else $error("push into a full transmit FIFO");

    // No pop from an empty receive FIFO
    no_pop_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
        rx_enable |-> rx_rdy)
        else $error("pop from an empty receive FIFO");

    // Client port closed in every test mode
    client_closed_in_test: assert property (@(posedge clk) disable iff (!reset_n)
        (test_mode != host_channel_pkg::NORMAL) |-> (!client_rx_rdy && !client_tx_rdy))
        else $error("client rdy high outside normal mode");

endmodule

bind host_channel_top host_channel_assertions host_channel_assertions_i
(
    .clk           (clk),
    .reset_n       (reset_n),
    .csr_req       (csr_req),
    .csr_ack       (csr_ack),
    .tx_enable     (tx_enable),
    .tx_rdy        (tx_rdy),
    .rx_enable     (rx_enable),
    .rx_rdy        (rx_rdy),
    .client_rx_rdy (client_rx_rdy),
    .client_tx_rdy (client_tx_rdy),
    .test_mode     (test_mode)
);

// ==== host_channel_tb.sv ====
// Testbench for the host channel test node
// Host and client traffic plus CSR writes come from a stimulus file
// Every word that arrives is compared with its expected queue
`timescale 1ns/100ps

module host_channel_tb;

    logic clk     = 1'b0;
    logic reset_n = 1'b0;

    // CSR write port
    logic                        csr_req   = 1'b0;
    host_channel_pkg::t_csr_addr csr_addr  = host_channel_pkg::CSR_CTRL;
    logic [31:0]                 csr_wdata = '0;
    logic                        csr_ack;

    // Host side of both paths
    host_channel_pkg::t_msg host_rx_data  = '0;
    logic                   host_rx_valid = 1'b0;
    logic                   host_rx_ready;
    host_channel_pkg::t_msg host_tx_data;
    logic                   host_tx_valid;
    logic                   host_tx_ready = 1'b0;

    // Client side of both paths
    host_channel_pkg::t_msg client_rx_data;
    logic                   client_rx_rdy;
    logic                   client_rx_enable = 1'b0;
    host_channel_pkg::t_msg client_tx_data   = '0;
    logic                   client_tx_enable = 1'b0;
    logic                   client_tx_rdy;

    host_channel_pkg::t_test_mode            test_mode;
    logic [host_channel_pkg::DONE_WIDTH-1:0] tests_done;

    // Words still to send, and words still expected
    host_channel_pkg::t_msg host_send_q[$];
    host_channel_pkg::t_msg client_send_q[$];
    host_channel_pkg::t_msg exp_host_q[$];
    host_channel_pkg::t_msg exp_client_q[$];

    // host_tx_ready pattern is 0 held low, 1 held high or 2 random
    int ready_pattern = 0;
    int seed          = 9;
    // Grows as stimulus lines are read
    int cycle_budget  = 100;

    host_channel_top host_channel_top_i
    (
        .clk              (clk),
        .reset_n          (reset_n),
        .csr_req          (csr_req),
        .csr_addr         (csr_addr),
        .csr_wdata        (csr_wdata),
        .csr_ack          (csr_ack),
        .host_rx_data     (host_rx_data),
        .host_rx_valid    (host_rx_valid),
        .host_rx_ready    (host_rx_ready),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_enable (client_tx_enable),
        .client_tx_rdy    (client_tx_rdy),
        .host_tx_data     (host_tx_data),
        .host_tx_valid    (host_tx_valid),
        .host_tx_ready    (host_tx_ready),
        .test_mode        (test_mode),
        .tests_done       (tests_done)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Run stopped after a failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run("Stopping at the first wrong value");
        end
    endtask

    // Word k of a batch counts up by two from the base and bit 0 marks the last one
    function automatic host_channel_pkg::t_msg make_word(input host_channel_pkg::t_msg base,
                                                         input int index, input logic last);
        host_channel_pkg::t_msg word;
        word    = base + (host_channel_pkg::t_msg'(index) << 1);
        word[0] = last;
        return word;
    endfunction

    // Target selects host send (0), client send (1), host expected (2) or client expected (3)
    task automatic add_words(input int target, input int count,
                             input host_channel_pkg::t_msg base, input logic last);
        host_channel_pkg::t_msg word;
        for (int k = 0; k < count; k++)
        begin
            word = make_word(base, k, last && (k == count - 1));
            case (target)
                0:       host_send_q.push_back(word);
                1:       client_send_q.push_back(word);
                2:       exp_host_q.push_back(word);
                default: exp_client_q.push_back(word);
            endcase
        end
    endtask

    // Source words carry the remaining count in bits 30:1 and the last flag in bit 0
    task automatic add_source_words(input int count);
        host_channel_pkg::t_msg word;
        for (int remaining = count; remaining >= 1; remaining--)
        begin
            word       = '0;
            word[30:1] = remaining[29:0];
            word[0]    = (remaining == 1);
            exp_host_q.push_back(word);
        end
    endtask

    task automatic read_operand(input int fd, output host_channel_pkg::t_msg value);
        int code;
        code = $fscanf(fd, " %h", value);
        if (code != 1)
        begin
            abort_run("Stimulus line is missing an operand");
        end
    endtask

    // Four-phase write with ack expected two sampling edges after each req change
    task automatic csr_write(input logic [31:0] addr, input logic [31:0] data);
        int cycles;
        @(posedge clk);
        csr_req   <= 1'b1;
        csr_addr  <= host_channel_pkg::t_csr_addr'(addr[0]);
        csr_wdata <= data;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (!csr_ack);
        check_value("csr_ack rise cycles", cycles, 2);
        csr_req <= 1'b0;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (csr_ack);
        check_value("csr_ack fall cycles", cycles, 2);
    endtask

    // Host sender shows the next word once the current one transfers
    always @(posedge clk)
    begin : host_sender
        if (host_rx_valid && host_rx_ready)
        begin
            void'(host_send_q.pop_front());
        end
        if (host_send_q.size() > 0)
        begin
            host_rx_valid <= 1'b1;
            host_rx_data  <= host_send_q[0];
        end
        else
        begin
            host_rx_valid <= 1'b0;
        end
    end

    // Host receiver with the selected ready pattern
    always @(posedge clk)
    begin : host_receiver
        host_channel_pkg::t_msg expected;
        int                     rnd;
        if (host_tx_valid && host_tx_ready)
        begin
            if (exp_host_q.size() == 0)
            begin
                abort_run("A word arrived at the host when none was expected");
            end
            expected = exp_host_q.pop_front();
            check_value("host_tx_data", host_tx_data, expected);
        end
        rnd = $random(seed);
        host_tx_ready <= (ready_pattern == 2) ? rnd[0] : (ready_pattern == 1);
    end

    // Client receiver pulses enable every other cycle while rdy is high
    always @(posedge clk)
    begin : client_receiver
        host_channel_pkg::t_msg expected;
        if (client_rx_enable)
        begin
            client_rx_enable <= 1'b0;
            if (exp_client_q.size() == 0)
            begin
                abort_run("A word reached the client when none was expected");
            end
            expected = exp_client_q.pop_front();
            check_value("client_rx_data", client_rx_data, expected);
        end
        else if (client_rx_rdy)
        begin
            client_rx_enable <= 1'b1;
        end
    end

    // Client sender follows the same pulse rule as the receiver
    always @(posedge clk)
    begin : client_sender
        if (client_tx_enable)
        begin
            client_tx_enable <= 1'b0;
            void'(client_send_q.pop_front());
        end
        else if (client_tx_rdy && (client_send_q.size() > 0))
        begin
            client_tx_enable <= 1'b1;
            client_tx_data   <= client_send_q[0];
        end
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_budget)
            begin
                abort_run("Timeout, the stimulus did not complete in its cycle budget");
            end
        end
    end

    initial
    begin : stimulus
        int                     fd;
        int                     code;
        logic [8*8-1:0]         cmd;
        logic [8*160-1:0]       line;
        host_channel_pkg::t_msg op_a;
        host_channel_pkg::t_msg op_b;
        host_channel_pkg::t_msg op_c;

        fd = $fopen("host_channel_stimulus.txt", "r");
        if (fd == 0)
        begin
            abort_run("Cannot open host_channel_stimulus.txt");
        end

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        while (!$feof(fd))
        begin
            @(negedge clk);
            cmd  = '0;
            code = $fscanf(fd, " %s", cmd);
            if (code != 1)
            begin
                break;
            end
            case (cmd)
                "#":
                begin
                    code = $fgets(line, fd);
                end
                "CSR":
                begin
                    read_operand(fd, op_a);
                    read_operand(fd, op_b);
                    cycle_budget = cycle_budget + 50;
                    csr_write(op_a[31:0], op_b[31:0]);
                end
                "HOST", "EXPH", "EXPC":
                begin
                    read_operand(fd, op_a);
                    read_operand(fd, op_b);
                    read_operand(fd, op_c);
                    cycle_budget = cycle_budget + 50 * int'(op_a);
                    add_words((cmd == "HOST") ? 0 : (cmd == "EXPH") ? 2 : 3,
                              int'(op_a), op_b, op_c[0]);
                end
                "CLIENT":
                begin
                    read_operand(fd, op_a);
                    read_operand(fd, op_b);
                    cycle_budget = cycle_budget + 50 * int'(op_a);
                    add_words(1, int'(op_a), op_b, 1'b0);
                end
                "EXPS":
                begin
                    read_operand(fd, op_a);
                    cycle_budget = cycle_budget + 50 * int'(op_a);
                    add_source_words(int'(op_a));
                end
                "READY":
                begin
                    read_operand(fd, op_a);
                    ready_pattern = int'(op_a);
                end
                "TXOFF":
                begin
                    // Wait for rdy to fall and require it to stay low
                    read_operand(fd, op_a);
                    cycle_budget = cycle_budget + 50 + int'(op_a);
                    while (client_tx_rdy)
                    begin
                        @(negedge clk);
                    end
                    repeat (int'(op_a))
                    begin
                        @(negedge clk);
                        check_value("client_tx_rdy", client_tx_rdy, 0);
                    end
                end
                "FLUSH":
                begin
                    while ((host_send_q.size() > 0) || (client_send_q.size() > 0) ||
                           (exp_host_q.size() > 0) || (exp_client_q.size() > 0))
                    begin
                        @(negedge clk);
                    end
                    @(negedge clk);
                end
                "MODE":
                begin
                    read_operand(fd, op_a);
                    check_value("test_mode", test_mode, op_a);
                end
                "DONE":
                begin
                    read_operand(fd, op_a);
                    check_value("tests_done", tests_done, op_a);
                end
                default:
                begin
                    abort_run("Unknown command in the stimulus file");
                end
            endcase
        end
        $fclose(fd);

        if ((exp_host_q.size() > 0) || (exp_client_q.size() > 0))
        begin
            abort_run("Stimulus ended with expected words never received");
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== host_channel_stimulus.txt ====
# Columns: command, then its hex operands
# CSR addr data | HOST/EXPH/EXPC n base last | CLIENT n base | EXPS n | READY 0/1/2 | TXOFF n
READY 1
EXPC 5 A5A5000000000100 0
HOST 5 A5A5000000000100 0
EXPH 4 5A5A000000000200 0
CLIENT 4 5A5A000000000200
TXOFF 10
CSR 0 1
FLUSH
MODE 0
DONE 0
# Back-pressure from the host
READY 0
EXPH A 0123456700000000 0
CLIENT A 0123456700000000
TXOFF 10
READY 2
FLUSH
# Loopback
EXPH 6 F0F0000000001000 1
CSR 1 3
MODE 3
HOST 6 F0F0000000001000 1
FLUSH
MODE 0
DONE 1
# Sink returns only the terminating word
EXPH 1 0000ABCD0000004A 1
CSR 1 1
MODE 1
HOST 6 0000ABCD00000040 1
FLUSH
MODE 0
DONE 2
# Source of 20 words under random ready
EXPS 14
CSR 1 52
FLUSH
MODE 0
DONE 3
# Source of a single word
READY 1
EXPS 1
CSR 1 6
FLUSH
MODE 0
DONE 4

// ==== host_channel.f ====
host_channel_pkg.sv
csr_regs.sv
channel_fifo.sv
channel_tester.sv
host_channel_top.sv
host_channel_assertions.sv
host_channel_tb.sv

// ==== Makefile ====
# Verilator simulation of the host channel test node
TOP = host_channel_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f host_channel.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
